/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_rv32_decode
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 arst_n = 1'b1; // Release just after the edge.
    end

endmodule

/* bench/tb_rv32_decode.sv */
module tb_rv32_decode;
    import rv32_pkg::*;

    localparam int drive_delay = 1;
    localparam int max_cycles  = 400; // About 55 words at 3 cycles each, plus the credit run.

    logic        clk;
    logic        arst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic        instr_ready;
    rv32_ctrl_t  ctrl;
    logic        ctrl_valid;
    logic        credit_return;
    int          seed;
    int          errors;
    int          checks;
    int          cycles;

    tb_clock_gen #(.period(8), .reset_cycles(2)) clk_gen_i (.clk(clk), .arst_n(arst_n));

    rv32_decode_stage #(
        .credits (2)
    ) dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .ctrl          (ctrl),
        .ctrl_valid    (ctrl_valid),
        .credit_return (credit_return)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word builders, expected bundles and the compare task
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input opcode_e opc);
        return {f7, rs2, rs1, f3, rd, opc}; // S and B words reuse f7 and rd as offsets.
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv32_ctrl_t alu_exp(input alu_op_e op, input logic sub_sra,
                                           input imm_e imm, input alu_src2_e src2);
        rv32_ctrl_t c;
        c             = '0;
        c.rs1_read    = 1'b1;
        c.rs2_read    = (src2 == src2_reg);
        c.rd_write    = 1'b1;
        c.imm         = imm;
        c.alu_op      = op;
        c.alu_sub_sra = sub_sra;
        c.alu_src1    = src1_reg;
        c.alu_src2    = src2;
        return c;
    endfunction

    function automatic rv32_ctrl_t branch_exp(input alu_op_e op, input branch_op_e br);
        rv32_ctrl_t c;
        c             = alu_exp(op, 1'b1, imm_b, src2_reg);
        c.rd_write    = 1'b0;
        c.branch_op   = br; // Target is pc + offset.
        return c;
    endfunction

    function automatic rv32_ctrl_t mem_exp(input logic store, input mem_width_e w,
                                           input logic zext);
        rv32_ctrl_t c;
        c                 = alu_exp(alu_add_sub, 1'b0, store ? imm_s : imm_i, src2_imm);
        c.rs2_read        = store;
        c.rd_write        = !store;
        c.mem_read        = !store;
        c.mem_write       = store;
        c.mem_width       = w;
        c.mem_zero_extend = zext;
        return c;
    endfunction

    function automatic rv32_ctrl_t csr_exp(input csr_op_e op, input logic use_imm,
                                           input logic rd_wr, input logic wr);
        rv32_ctrl_t c;
        c           = '0;
        c.rs1_read  = !use_imm;
        c.rd_write  = rd_wr;
        c.csr_read  = rd_wr;
        c.csr_write = wr;
        c.csr_op    = op;
        c.csr_src   = use_imm ? csr_src_imm : csr_src_reg;
        c.imm       = use_imm ? imm_zimm : imm_none;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Drives one word, checks the bundle after acceptance, then hands the credit back.
    task automatic issue_word(input logic [31:0] word, input rv32_ctrl_t exp,
                              input string name);
        instr       = word;
        instr_valid = 1'b1;
        while (!instr_ready) begin
            @(posedge clk);
            #drive_delay;
        end
        @(posedge clk);
        #drive_delay;
        instr_valid = 1'b0;
        instr       = '0;
        check_value($sformatf("ctrl_valid (%s)", name), ctrl_valid, 1'b1);
        check_value($sformatf("ctrl (%s)", name), ctrl, exp);
        credit_return = 1'b1;
        @(posedge clk);
        #drive_delay;
        credit_return = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic alu_instructions();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] imm;
        rv32_ctrl_t  e;
        rs1 = 5'($random(seed));
        rs2 = 5'($random(seed));
        rd  = 5'($random(seed));
        imm = 12'($random(seed));
        issue_word(r_word(7'h00, rs2, rs1, 3'd0, rd, opc_op),
                   alu_exp(alu_add_sub, 1'b0, imm_none, src2_reg), "add");
        issue_word(r_word(7'h20, rs2, rs1, 3'd0, rd, opc_op),
                   alu_exp(alu_add_sub, 1'b1, imm_none, src2_reg), "sub");
        issue_word(r_word(7'h00, rs2, rs1, 3'd2, rd, opc_op),
                   alu_exp(alu_slt, 1'b1, imm_none, src2_reg), "slt");
        issue_word(r_word(7'h00, rs2, rs1, 3'd3, rd, opc_op),
                   alu_exp(alu_sltu, 1'b1, imm_none, src2_reg), "sltu");
        issue_word(r_word(7'h00, rs2, rs1, 3'd4, rd, opc_op),
                   alu_exp(alu_xor, 1'b0, imm_none, src2_reg), "xor");
        issue_word(r_word(7'h00, rs2, rs1, 3'd6, rd, opc_op),
                   alu_exp(alu_or, 1'b0, imm_none, src2_reg), "or");
        issue_word(r_word(7'h00, rs2, rs1, 3'd7, rd, opc_op),
                   alu_exp(alu_and, 1'b0, imm_none, src2_reg), "and");
        issue_word(r_word(7'h00, rs2, rs1, 3'd1, rd, opc_op),
                   alu_exp(alu_sll, 1'b0, imm_none, src2_reg), "sll");
        issue_word(r_word(7'h00, rs2, rs1, 3'd5, rd, opc_op),
                   alu_exp(alu_srl_sra, 1'b0, imm_none, src2_reg), "srl");
        issue_word(r_word(7'h20, rs2, rs1, 3'd5, rd, opc_op),
                   alu_exp(alu_srl_sra, 1'b1, imm_none, src2_reg), "sra");
        issue_word(i_word(imm, rs1, 3'd0, rd, opc_op_imm),
                   alu_exp(alu_add_sub, 1'b0, imm_i, src2_imm), "addi");
        issue_word(i_word(imm, rs1, 3'd2, rd, opc_op_imm),
                   alu_exp(alu_slt, 1'b1, imm_i, src2_imm), "slti");
        issue_word(i_word(imm, rs1, 3'd3, rd, opc_op_imm),
                   alu_exp(alu_sltu, 1'b1, imm_i, src2_imm), "sltiu");
        issue_word(i_word(imm, rs1, 3'd4, rd, opc_op_imm),
                   alu_exp(alu_xor, 1'b0, imm_i, src2_imm), "xori");
        issue_word(i_word(imm, rs1, 3'd6, rd, opc_op_imm),
                   alu_exp(alu_or, 1'b0, imm_i, src2_imm), "ori");
        issue_word(i_word(imm, rs1, 3'd7, rd, opc_op_imm),
                   alu_exp(alu_and, 1'b0, imm_i, src2_imm), "andi");
        issue_word(i_word({7'h00, rs2}, rs1, 3'd1, rd, opc_op_imm),
                   alu_exp(alu_sll, 1'b0, imm_shamt, src2_imm), "slli");
        issue_word(i_word({7'h00, rs2}, rs1, 3'd5, rd, opc_op_imm),
                   alu_exp(alu_srl_sra, 1'b0, imm_shamt, src2_imm), "srli");
        issue_word(i_word({7'h20, rs2}, rs1, 3'd5, rd, opc_op_imm),
                   alu_exp(alu_srl_sra, 1'b1, imm_shamt, src2_imm), "srai");
        e          = alu_exp(alu_add_sub, 1'b0, imm_u, src2_imm);
        e.rs1_read = 1'b0;
        e.alu_src1 = src1_zero;
        issue_word(i_word(imm, rs1, 3'd5, rd, opc_lui), e, "lui");
        e.alu_src1 = src1_pc;
        issue_word(i_word(imm, rs1, 3'd2, rd, opc_auipc), e, "auipc");
    endtask

    task automatic branches_and_jumps();
        rv32_ctrl_t e;
        issue_word(r_word(7'h12, 5'd2, 5'd1, 3'd0, 5'd8, opc_branch),
                   branch_exp(alu_add_sub, br_zero), "beq");
        issue_word(r_word(7'h12, 5'd2, 5'd1, 3'd1, 5'd8, opc_branch),
                   branch_exp(alu_add_sub, br_non_zero), "bne");
        issue_word(r_word(7'h12, 5'd2, 5'd1, 3'd4, 5'd8, opc_branch),
                   branch_exp(alu_slt, br_non_zero), "blt");
        issue_word(r_word(7'h12, 5'd2, 5'd1, 3'd5, 5'd8, opc_branch),
                   branch_exp(alu_slt, br_zero), "bge");
        issue_word(r_word(7'h12, 5'd2, 5'd1, 3'd6, 5'd8, opc_branch),
                   branch_exp(alu_sltu, br_non_zero), "bltu");
        issue_word(r_word(7'h12, 5'd2, 5'd1, 3'd7, 5'd8, opc_branch),
                   branch_exp(alu_sltu, br_zero), "bgeu");
        e           = '0;
        e.rd_write  = 1'b1;
        e.imm       = imm_j;
        e.alu_src1  = src1_pc; // Link value pc + 4.
        e.alu_src2  = src2_four;
        e.branch_op = br_always;
        issue_word(i_word(12'h5a4, 5'd9, 3'd3, 5'd1, opc_jal), e, "jal");
        e.rs1_read      = 1'b1;
        e.imm           = imm_i;
        e.branch_pc_src = pc_src_reg;
        issue_word(i_word(12'h010, 5'd6, 3'd0, 5'd1, opc_jalr), e, "jalr");
    endtask

    task automatic memory_instructions();
        rv32_ctrl_t e;
        issue_word(i_word(12'h004, 5'd2, 3'd0, 5'd3, opc_load),
                   mem_exp(1'b0, width_byte, 1'b0), "lb");
        issue_word(i_word(12'h004, 5'd2, 3'd1, 5'd3, opc_load),
                   mem_exp(1'b0, width_half, 1'b0), "lh");
        issue_word(i_word(12'h004, 5'd2, 3'd2, 5'd3, opc_load),
                   mem_exp(1'b0, width_word, 1'b0), "lw");
        issue_word(i_word(12'h004, 5'd2, 3'd4, 5'd3, opc_load),
                   mem_exp(1'b0, width_byte, 1'b1), "lbu");
        issue_word(i_word(12'h004, 5'd2, 3'd5, 5'd3, opc_load),
                   mem_exp(1'b0, width_half, 1'b1), "lhu");
        issue_word(r_word(7'h01, 5'd4, 5'd2, 3'd0, 5'd8, opc_store),
                   mem_exp(1'b1, width_byte, 1'b0), "sb");
        issue_word(r_word(7'h01, 5'd4, 5'd2, 3'd1, 5'd8, opc_store),
                   mem_exp(1'b1, width_half, 1'b0), "sh");
        issue_word(r_word(7'h01, 5'd4, 5'd2, 3'd2, 5'd8, opc_store),
                   mem_exp(1'b1, width_word, 1'b0), "sw");
        e = '0;
        issue_word(i_word(12'h0ff, 5'd0, 3'd0, 5'd0, opc_misc_mem), e, "fence");
        e.mem_fence = 1'b1;
        issue_word(i_word(12'h000, 5'd0, 3'd1, 5'd0, opc_misc_mem), e, "fence.i");
    endtask

    task automatic system_instructions();
        rv32_ctrl_t e;
        e       = '0;
        e.ecall = 1'b1;
        issue_word(i_word(12'h000, 5'd0, 3'd0, 5'd0, opc_system), e, "ecall");
        e        = '0;
        e.ebreak = 1'b1;
        issue_word(i_word(12'h001, 5'd0, 3'd0, 5'd0, opc_system), e, "ebreak");
        e      = '0;
        e.mret = 1'b1;
        issue_word(i_word(12'h302, 5'd0, 3'd0, 5'd0, opc_system), e, "mret");
        e = '0; // WFI is legal and raises nothing.
        issue_word(i_word(12'h105, 5'd0, 3'd0, 5'd0, opc_system), e, "wfi");
        issue_word(i_word(12'h300, 5'd5, 3'd1, 5'd0, opc_system),
                   csr_exp(csr_rw, 1'b0, 1'b0, 1'b1), "csrrw rd=x0");
        issue_word(i_word(12'h300, 5'd5, 3'd1, 5'd3, opc_system),
                   csr_exp(csr_rw, 1'b0, 1'b1, 1'b1), "csrrw");
        issue_word(i_word(12'h341, 5'd0, 3'd2, 5'd4, opc_system),
                   csr_exp(csr_rs, 1'b0, 1'b1, 1'b0), "csrrs rs1=x0");
        issue_word(i_word(12'h341, 5'd7, 3'd3, 5'd4, opc_system),
                   csr_exp(csr_rc, 1'b0, 1'b1, 1'b1), "csrrc");
        issue_word(i_word(12'h305, 5'd9, 3'd5, 5'd2, opc_system),
                   csr_exp(csr_rw, 1'b1, 1'b1, 1'b1), "csrrwi");
        issue_word(i_word(12'h305, 5'd0, 3'd6, 5'd2, opc_system),
                   csr_exp(csr_rs, 1'b1, 1'b1, 1'b0), "csrrsi zimm=0");
        issue_word(i_word(12'h305, 5'd3, 3'd7, 5'd2, opc_system),
                   csr_exp(csr_rc, 1'b1, 1'b1, 1'b1), "csrrci");
    endtask

    task automatic illegal_words();
        rv32_ctrl_t e;
        e         = '0;
        e.illegal = 1'b1;
        issue_word(32'h0000_0000, e, "all-zero word");
        issue_word(r_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, opc_op), e, "op bad funct7");
    endtask

    // Fetch keeps offering words while execute returns a single credit.
    task automatic credit_backpressure();
        int exp_cnt;
        int valid_seen;
        logic exp_valid;
        exp_cnt     = 2;
        valid_seen  = 0;
        exp_valid   = 1'b0;
        instr       = i_word(12'h011, 5'd1, 3'd0, 5'd2, opc_op_imm);
        instr_valid = 1'b1;
        for (int cyc = 0; cyc < 10; cyc++) begin
            credit_return = (cyc == 5);
            check_value($sformatf("instr_ready (cycle %0d)", cyc), instr_ready, exp_cnt != 0);
            check_value($sformatf("ctrl_valid (cycle %0d)", cyc), ctrl_valid, exp_valid);
            if (ctrl_valid)
                valid_seen++;
            exp_valid = (exp_cnt != 0);
            exp_cnt   = exp_cnt - int'(exp_valid) + int'(credit_return);
            @(posedge clk);
            #drive_delay;
        end
        instr_valid   = 1'b0;
        credit_return = 1'b0;
        check_value("ctrl_valid pulses", 64'(valid_seen), 64'd3);
        check_value("instr_ready after drain", instr_ready, 1'b0);
    endtask

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles.", max_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed          = 91132;
        errors        = 0;
        checks        = 0;
        instr         = '0;
        instr_valid   = 1'b0;
        credit_return = 1'b0;
        @(posedge arst_n);
        @(posedge clk);
        #drive_delay;
        check_value("ctrl_valid after reset", ctrl_valid, 1'b0);
        check_value("instr_ready after reset", instr_ready, 1'b1);
        check_value("ctrl after reset", ctrl, '0);
        alu_instructions();
        branches_and_jumps();
        memory_instructions();
        system_instructions();
        illegal_words();
        credit_backpressure();
        $display("Decode tests done: %0d checks, %0d errors.", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* build.f */
hdl/rv32_pkg.sv
hdl/rv32_exec_decode.sv
hdl/rv32_mem_decode.sv
hdl/rv32_sys_decode.sv
hdl/rv32_decode_issue.sv
hdl/rv32_decode_stage.sv
bench/tb_clock_gen.sv
bench/tb_rv32_decode.sv

/* hdl/rv32_decode_issue.sv */
module rv32_decode_issue #(
    parameter int unsigned credits = 2
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  rv32_pkg::exec_ctrl_t exec,
    input  rv32_pkg::mem_ctrl_t  mem,
    input  rv32_pkg::sys_ctrl_t  sys,
    input  logic                 credit_return,
    output rv32_pkg::rv32_ctrl_t ctrl,
    output logic                 ctrl_valid
);
    import rv32_pkg::*;

    localparam int unsigned cnt_w = $clog2(credits + 1);

    logic [cnt_w-1:0] credit_cnt;
    logic             accept;
    rv32_ctrl_t       bundle;

    assign instr_ready = (credit_cnt != '0);
    assign accept      = instr_valid && instr_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Merge of the group results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        bundle                 = '0;
        bundle.illegal         = !(exec.hit || mem.hit || sys.hit);
        bundle.rs1_read        = exec.rs1_read | sys.rs1_read;
        bundle.rs2_read        = exec.rs2_read;
        bundle.rd_write        = exec.rd_write | sys.rd_write;
        bundle.imm             = sys.imm_zimm ? imm_zimm : exec.imm;
        bundle.alu_op          = exec.alu_op;
        bundle.alu_sub_sra     = exec.alu_sub_sra;
        bundle.alu_src1        = exec.alu_src1;
        bundle.alu_src2        = exec.alu_src2;
        bundle.branch_op       = exec.branch_op;
        bundle.branch_pc_src   = exec.branch_pc_src;
        bundle.mem_read        = mem.read;
        bundle.mem_write       = mem.write;
        bundle.mem_width       = mem.width;
        bundle.mem_zero_extend = mem.zero_extend;
        bundle.mem_fence       = mem.fence;
        bundle.csr_read        = sys.csr_read;
        bundle.csr_write       = sys.csr_write;
        bundle.csr_op          = sys.csr_op;
        bundle.csr_src         = sys.csr_src;
        bundle.ecall           = sys.ecall;
        bundle.ebreak          = sys.ebreak;
        bundle.mret            = sys.mret;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= cnt_w'(credits); // Execute buffer starts empty.
            ctrl_valid <= 1'b0;
            ctrl       <= '0;
        end else begin
            ctrl_valid <= accept;
            if (accept)
                ctrl <= bundle;
            if (accept && !credit_return)
                credit_cnt <= credit_cnt - 1'b1;
            else if (!accept && credit_return)
                credit_cnt <= credit_cnt + 1'b1;
        end
    end

endmodule

/* hdl/rv32_decode_stage.sv */
module rv32_decode_stage #(
    parameter int unsigned credits = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv32_pkg::rv32_instr_u instr,
    input  logic                  instr_valid,
    output logic                  instr_ready,
    output rv32_pkg::rv32_ctrl_t  ctrl,
    output logic                  ctrl_valid,
    input  logic                  credit_return
);
    import rv32_pkg::*;

    exec_ctrl_t exec;
    mem_ctrl_t  mem;
    sys_ctrl_t  sys;

    rv32_exec_decode exec_dec_i (
        .instr (instr),
        .exec  (exec)
    );

    rv32_mem_decode mem_dec_i (
        .instr (instr),
        .mem   (mem)
    );

    rv32_sys_decode sys_dec_i (
        .instr (instr),
        .sys   (sys)
    );

    rv32_decode_issue #(
        .credits (credits)
    ) issue_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .exec          (exec),
        .mem           (mem),
        .sys           (sys),
        .credit_return (credit_return),
        .ctrl          (ctrl),
        .ctrl_valid    (ctrl_valid)
    );

endmodule

/* hdl/rv32_exec_decode.sv */
module rv32_exec_decode (
    input  rv32_pkg::rv32_instr_u instr,
    output rv32_pkg::exec_ctrl_t  exec
);
    import rv32_pkg::*;

    logic legal;
    logic is_reg;
    logic is_shift;

    assign is_reg   = (instr.r.opcode == opc_op);
    assign is_shift = (instr.r.funct3 == 3'b001) || (instr.r.funct3 == 3'b101);

    always_comb begin
        exec  = '0;
        legal = 1'b0;
        case (instr.r.opcode)
            opc_lui, opc_auipc: begin
                legal         = 1'b1;
                exec.rd_write = 1'b1;
                exec.imm      = imm_u;
                exec.alu_src1 = (instr.u.opcode == opc_auipc) ? src1_pc : src1_zero;
                exec.alu_src2 = src2_imm;
            end
            opc_jal, opc_jalr: begin
                legal              = (instr.i.opcode == opc_jal) || (instr.i.funct3 == 3'b000);
                exec.rs1_read      = (instr.i.opcode == opc_jalr);
                exec.rd_write      = 1'b1;
                exec.imm           = (instr.i.opcode == opc_jalr) ? imm_i : imm_j;
                exec.alu_src1      = src1_pc; // Link value is pc + 4.
                exec.alu_src2      = src2_four;
                exec.branch_op     = br_always;
                exec.branch_pc_src = (instr.i.opcode == opc_jalr) ? pc_src_reg : pc_src_imm;
            end
            opc_branch: begin
                legal              = (instr.b.funct3[2:1] != 2'b01);
                exec.rs1_read      = 1'b1;
                exec.rs2_read      = 1'b1;
                exec.imm           = imm_b;
                exec.alu_op        = !instr.b.funct3[2] ? alu_add_sub :
                                     (instr.b.funct3[1] ? alu_sltu : alu_slt);
                exec.alu_sub_sra   = 1'b1;
                exec.alu_src1      = src1_reg;
                exec.alu_src2      = src2_reg;
                exec.branch_op     = (instr.b.funct3[0] ^ instr.b.funct3[2]) ? br_non_zero : br_zero;
                exec.branch_pc_src = pc_src_imm;
            end
            opc_load, opc_store: begin
                if (instr.s.opcode == opc_store)
                    legal = (instr.s.funct3 < 3'b011);
                else
                    legal = (instr.i.funct3 != 3'b011) && (instr.i.funct3[2:1] != 2'b11);
                exec.rs1_read = 1'b1;
                exec.rs2_read = (instr.s.opcode == opc_store);
                exec.rd_write = (instr.i.opcode == opc_load);
                exec.imm      = (instr.s.opcode == opc_store) ? imm_s : imm_i;
                exec.alu_src1 = src1_reg; // Address is rs1 + offset.
                exec.alu_src2 = src2_imm;
            end
            opc_op_imm, opc_op: begin
                if (is_reg)
                    legal = (instr.r.funct7 == 7'b0000000) || ((instr.r.funct7 == 7'b0100000) &&
                            (instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101));
                else if (instr.i.funct3 == 3'b001)
                    legal = (instr.r.funct7 == 7'b0000000);
                else if (instr.i.funct3 == 3'b101)
                    legal = ((instr.r.funct7 & 7'b1011111) == 7'b0000000);
                else
                    legal = 1'b1;
                exec.rs1_read    = 1'b1;
                exec.rs2_read    = is_reg;
                exec.rd_write    = 1'b1;
                exec.imm         = is_reg ? imm_none : (is_shift ? imm_shamt : imm_i);
                exec.alu_op      = alu_op_e'({1'b0, instr.r.funct3});
                exec.alu_sub_sra = (instr.r.funct3 == 3'b010) || (instr.r.funct3 == 3'b011) ||
                                   (instr.r.funct7[5] && ((instr.r.funct3 == 3'b101) ||
                                   (is_reg && instr.r.funct3 == 3'b000))); // SUB, SRA, compares.
                exec.alu_src1    = src1_reg;
                exec.alu_src2    = is_reg ? src2_reg : src2_imm;
            end
            default: ;
        endcase
        if (legal)
            exec.hit = 1'b1;
        else
            exec = '0;
    end

endmodule

/* hdl/rv32_mem_decode.sv */
module rv32_mem_decode (
    input  rv32_pkg::rv32_instr_u instr,
    output rv32_pkg::mem_ctrl_t   mem
);
    import rv32_pkg::*;

    always_comb begin
        mem = '0;
        case (instr.i.opcode)
            opc_load: begin
                // LB, LH, LW, LBU, LHU.
                if ((instr.i.funct3 != 3'b011) && (instr.i.funct3[2:1] != 2'b11)) begin
                    mem.hit         = 1'b1;
                    mem.read        = 1'b1;
                    mem.width       = mem_width_e'(instr.i.funct3[1:0]);
                    mem.zero_extend = instr.i.funct3[2]; // Unsigned forms.
                end
            end
            opc_store: begin
                if (instr.s.funct3 < 3'b011) begin
                    mem.hit   = 1'b1;
                    mem.write = 1'b1;
                    mem.width = mem_width_e'(instr.s.funct3[1:0]);
                end
            end
            opc_misc_mem: begin
                if (instr.i.funct3[2:1] == 2'b00) begin
                    mem.hit   = 1'b1;
                    mem.fence = instr.i.funct3[0]; // FENCE.I only.
                end
            end
            default: ;
        endcase
    end

endmodule

/* hdl/rv32_pkg.sv */
package rv32_pkg;

    parameter int unsigned xlen       = 32;
    parameter int unsigned reg_addr_w = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [6:0] {
        opc_lui      = 7'b0110111,
        opc_auipc    = 7'b0010111,
        opc_jal      = 7'b1101111,
        opc_jalr     = 7'b1100111,
        opc_branch   = 7'b1100011,
        opc_load     = 7'b0000011,
        opc_store    = 7'b0100011,
        opc_op_imm   = 7'b0010011,
        opc_op       = 7'b0110011,
        opc_misc_mem = 7'b0001111,
        opc_system   = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        imm_none, imm_i, imm_s, imm_b, imm_u, imm_j, imm_shamt, imm_zimm
    } imm_e;

    // Order follows funct3 of OP and OP-IMM.
    typedef enum logic [3:0] {
        alu_add_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [1:0] {src1_zero, src1_reg, src1_pc} alu_src1_e;
    typedef enum logic [1:0] {src2_zero, src2_reg, src2_imm, src2_four} alu_src2_e;
    typedef enum logic [1:0] {br_never, br_zero, br_non_zero, br_always} branch_op_e;
    typedef enum logic {pc_src_imm, pc_src_reg} pc_src_e;
    typedef enum logic [1:0] {width_byte, width_half, width_word} mem_width_e;
    typedef enum logic [1:0] {csr_none, csr_rw, csr_rs, csr_rc} csr_op_e; // Matches funct3[1:0].
    typedef enum logic {csr_src_reg, csr_src_imm} csr_src_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        opcode_e               opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        opcode_e               opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_e               opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [xlen-1:12]      imm_31_12; // J immediate is a shuffle of the same bits.
        logic [reg_addr_w-1:0] rd;
        opcode_e               opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } rv32_instr_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Group results and issued bundle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic       hit;
        logic       rs1_read;
        logic       rs2_read;
        logic       rd_write;
        imm_e       imm;
        alu_op_e    alu_op;
        logic       alu_sub_sra;
        alu_src1_e  alu_src1;
        alu_src2_e  alu_src2;
        branch_op_e branch_op;
        pc_src_e    branch_pc_src;
    } exec_ctrl_t;

    typedef struct packed {
        logic       hit;
        logic       read;
        logic       write;
        mem_width_e width;
        logic       zero_extend;
        logic       fence;
    } mem_ctrl_t;

    typedef struct packed {
        logic     hit;
        logic     rs1_read;
        logic     rd_write;
        logic     imm_zimm;
        logic     csr_read;
        logic     csr_write;
        csr_op_e  csr_op;
        csr_src_e csr_src;
        logic     ecall;
        logic     ebreak;
        logic     mret;
    } sys_ctrl_t;

    typedef struct packed {
        logic       illegal;
        logic       rs1_read;
        logic       rs2_read;
        logic       rd_write;
        imm_e       imm;
        alu_op_e    alu_op;
        logic       alu_sub_sra;
        alu_src1_e  alu_src1;
        alu_src2_e  alu_src2;
        branch_op_e branch_op;
        pc_src_e    branch_pc_src;
        logic       mem_read;
        logic       mem_write;
        mem_width_e mem_width;
        logic       mem_zero_extend;
        logic       mem_fence;
        logic       csr_read;
        logic       csr_write;
        csr_op_e    csr_op;
        csr_src_e   csr_src;
        logic       ecall;
        logic       ebreak;
        logic       mret;
    } rv32_ctrl_t;

endpackage

/* hdl/rv32_sys_decode.sv */
module rv32_sys_decode (
    input  rv32_pkg::rv32_instr_u instr,
    output rv32_pkg::sys_ctrl_t   sys
);
    import rv32_pkg::*;

    localparam logic [31:0] ecall_word  = 32'h0000_0073;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;
    localparam logic [31:0] mret_word   = 32'h3020_0073;
    localparam logic [31:0] wfi_word    = 32'h1050_0073;

    logic is_rw;
    logic rd_nz;
    logic rs1_nz;

    assign is_rw  = (instr.i.funct3[1:0] == 2'b01);
    assign rd_nz  = |instr.i.rd;
    assign rs1_nz = |instr.i.rs1; // Holds zimm in the immediate forms.

    always_comb begin
        sys = '0;
        if (instr.i.opcode == opc_system) begin
            if (instr.i.funct3 == 3'b000) begin
                case (instr)
                    ecall_word: begin
                        sys.hit   = 1'b1;
                        sys.ecall = 1'b1;
                    end
                    ebreak_word: begin
                        sys.hit    = 1'b1;
                        sys.ebreak = 1'b1;
                    end
                    mret_word: begin
                        sys.hit  = 1'b1;
                        sys.mret = 1'b1;
                    end
                    wfi_word: sys.hit = 1'b1; // Treated as a nop.
                    default: ;
                endcase
            end else if (instr.i.funct3 != 3'b100) begin
                sys.hit       = 1'b1;
                sys.rs1_read  = !instr.i.funct3[2];
                sys.imm_zimm  = instr.i.funct3[2];
                sys.csr_op    = csr_op_e'(instr.i.funct3[1:0]);
                sys.csr_src   = instr.i.funct3[2] ? csr_src_imm : csr_src_reg;
                sys.csr_read  = is_rw ? rd_nz : 1'b1; // No read side effect to x0.
                sys.rd_write  = is_rw ? rd_nz : 1'b1;
                sys.csr_write = is_rw ? 1'b1 : rs1_nz; // Set or clear with 0 is read only.
            end
        end
    end

endmodule
